// ==== Makefile ====
# build and run the testbench with Verilator
TOP := mem_system_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f list.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== design/addr_pkg.sv ====
/*
 plain vector types for address fields and data words
 word_sel_t doubles as the bank number, so the number of banks
 must equal the number of words in a line
*/
`default_nettype none

`include "mem_config.svh"

package addr_pkg;

   // full byte address
   typedef logic [`ADDR_W-1:0] addr_t;

   // one data word
   typedef logic [`DATA_W-1:0] word_t;

   // line tag and line index
   typedef logic [`TAG_W-1:0] tag_t;
   typedef logic [`INDEX_W-1:0] index_t;

   // word within a line, also the bank
   typedef logic [$clog2(`WORDS_PER_LINE)-1:0] word_sel_t;

   // memory word address, byte address without bit 0
   typedef logic [`ADDR_W-2:0] word_addr_t;

endpackage

`default_nettype wire

// ==== design/banked_mem.sv ====
/*
 word-interleaved main memory, bank = word address bits 1:0
 one request per cycle; ready is low while the addressed bank is busy
 a bank stays busy BANK_BUSY_CYCLES cycles after any accepted request
 read data returns MEM_RD_LATENCY cycles after acceptance, in order
 contents are not initialised; reading unwritten words gives unknowns
*/
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

module banked_mem (
   input  logic                   clk,
   input  logic                   rst,
   input  mem_bus_pkg::mem_req_t  req,
   output logic                   ready,
   output mem_bus_pkg::mem_resp_t resp
);
   import addr_pkg::*;

   localparam int CNT_W = $clog2(`BANK_BUSY_CYCLES + 1);
   localparam int LAT   = `MEM_RD_LATENCY;

   word_t            mem       [`MEM_WORDS];
   logic [CNT_W-1:0] busy_cnt  [`NUM_BANKS];
   word_t            pipe_data [LAT];
   logic [LAT-1:0]   pipe_valid;

   word_sel_t bank;
   logic      accept;

   // low address bits pick the bank
   assign bank   = word_sel_t'(req.word_addr);
   assign ready  = (busy_cnt[bank] == '0);
   assign accept = req.valid & ready;

   // per-bank busy timers
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int b = 0; b < `NUM_BANKS; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < `NUM_BANKS; b++) begin
            if (accept && bank == word_sel_t'(b)) begin
               busy_cnt[b] <= CNT_W'(`BANK_BUSY_CYCLES);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   // storage and read data pipeline
   always_ff @(posedge clk) begin
      if (accept && req.write) begin
         mem[req.word_addr] <= req.wdata;
      end
      pipe_data[0] <= mem[req.word_addr];
      for (int s = 1; s < LAT; s++) begin
         pipe_data[s] <= pipe_data[s-1];
      end
   end

   // valid bits follow the data through the pipeline
   always_ff @(posedge clk) begin
      if (rst) begin
         pipe_valid <= '0;
      end else begin
         pipe_valid[0] <= accept & ~req.write;
         for (int s = 1; s < LAT; s++) begin
            pipe_valid[s] <= pipe_valid[s-1];
         end
      end
   end

   assign resp.valid = pipe_valid[LAT-1];
   assign resp.rdata = pipe_data[LAT-1];

endmodule

`default_nettype wire

// ==== design/cache_array.sv ====
/*
 direct-mapped line store: tag, valid, dirty and four words per line
 status is combinational from the op of the same cycle
 compare-mode writes only land on a valid line with a matching tag
 access-mode writes load the tag and clear dirty, meant for fills
 reset clears valid and dirty only; tags and data keep their values
*/
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

module cache_array (
   input  logic                     clk,
   input  logic                     rst,
   input  mem_bus_pkg::cache_op_t   op,
   output mem_bus_pkg::cache_stat_t stat
);
   import addr_pkg::*;

   localparam int NUM_LINES = 1 << `INDEX_W;

   tag_t                 tag_mem  [NUM_LINES];
   word_t                data_mem [NUM_LINES][`WORDS_PER_LINE];
   logic [NUM_LINES-1:0] valid_bits;
   logic [NUM_LINES-1:0] dirty_bits;

   logic tag_eq;
   logic comp_wr;
   logic fill_wr;

   assign tag_eq = (tag_mem[op.index] == op.tag);

   // compare write needs a real hit
   assign comp_wr = op.enable & op.comp & op.write & valid_bits[op.index] & tag_eq;
   assign fill_wr = op.enable & ~op.comp & op.write;

   // status for the addressed line and word
   always_comb begin
      stat.hit     = tag_eq;
      stat.valid   = valid_bits[op.index];
      stat.dirty   = dirty_bits[op.index];
      stat.tag_out = tag_mem[op.index];
      stat.rdata   = data_mem[op.index][op.word_sel];
   end

   // word and tag storage
   always_ff @(posedge clk) begin
      if (comp_wr || fill_wr) begin
         data_mem[op.index][op.word_sel] <= op.wdata;
      end
      if (fill_wr) begin
         tag_mem[op.index] <= op.tag;
      end
   end

   // line state bits
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (fill_wr) begin
         valid_bits[op.index] <= op.valid_in;
         dirty_bits[op.index] <= 1'b0;
      end else if (comp_wr) begin
         dirty_bits[op.index] <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== design/cache_ctrl.sv ====
/*
 cache controller: serves hits in one cycle, runs writeback and fill
 requests are taken whenever stall is low, including the done cycle
 rd and wr both high, or addr bit 0 set, gives err and no access
 at most two fill reads are kept in flight
 a miss ends with a compare-mode redo, reported with cache_hit low
*/
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

module cache_ctrl (
   input  logic                     clk,
   input  logic                     rst,
   input  addr_pkg::addr_t          addr,
   input  addr_pkg::word_t          data_in,
   input  logic                     rd,
   input  logic                     wr,
   input  mem_bus_pkg::cache_stat_t stat,
   output mem_bus_pkg::cache_op_t   op,
   output mem_bus_pkg::mem_req_t    mem_req,
   input  logic                     mem_ready,
   input  mem_bus_pkg::mem_resp_t   mem_resp,
   output logic                     done,
   output logic                     stall,
   output logic                     cache_hit,
   output logic                     err
);
   import addr_pkg::*;
   import mem_bus_pkg::*;

   localparam word_sel_t LAST_WORD     = word_sel_t'(`WORDS_PER_LINE - 1);
   localparam word_sel_t MAX_IN_FLIGHT = word_sel_t'(2);

   ctrl_state_t state;
   ctrl_state_t state_nxt;

   // latched request
   addr_t  req_addr;
   word_t  req_data;
   logic   req_wr;
   logic   req_err;
   tag_t   req_tag;
   index_t req_index;
   word_sel_t req_word;

   // fill bookkeeping
   word_sel_t issue_cnt;
   word_sel_t recv_cnt;
   word_sel_t in_flight;

   logic line_hit;
   logic accept;
   logic mem_accept;

   assign req_tag   = req_addr[`ADDR_W-1 -: `TAG_W];
   assign req_index = req_addr[`OFFSET_W +: `INDEX_W];
   assign req_word  = req_addr[`OFFSET_W-1:1];

   assign line_hit   = stat.hit & stat.valid;
   assign accept     = (rd | wr) & ~stall;
   assign mem_accept = mem_req.valid & mem_ready;
   assign in_flight  = issue_cnt - recv_cnt;

   // request payload
   always_ff @(posedge clk) begin
      if (accept) begin
         req_addr <= addr;
         req_data <= data_in;
      end
   end

   // state, counters and request flags
   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= IDLE;
         issue_cnt <= '0;
         recv_cnt  <= '0;
         req_wr    <= 1'b0;
         req_err   <= 1'b0;
      end else begin
         state <= state_nxt;
         if (accept) begin
            issue_cnt <= '0;
            recv_cnt  <= '0;
            req_wr    <= wr;
            req_err   <= (rd & wr) | addr[0];
         end else begin
            // writeback words also count through issue_cnt
            if (mem_accept) begin
               issue_cnt <= issue_cnt + 1'b1;
            end
            if (mem_resp.valid) begin
               recv_cnt <= recv_cnt + 1'b1;
            end
         end
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (accept) begin
               state_nxt = HIT_DONE;
            end
         end
         HIT_DONE: begin
            if (!req_err && !line_hit) begin
               state_nxt = (stat.valid && stat.dirty) ? WB_ISSUE : FILL_ISSUE;
            end else begin
               state_nxt = accept ? HIT_DONE : IDLE;
            end
         end
         WB_ISSUE: begin
            if (mem_accept && issue_cnt == LAST_WORD) begin
               state_nxt = FILL_ISSUE;
            end
         end
         FILL_ISSUE: begin
            if (mem_accept && issue_cnt == LAST_WORD) begin
               state_nxt = FILL_WAIT;
            end
         end
         FILL_WAIT: begin
            if (mem_resp.valid && recv_cnt == LAST_WORD) begin
               state_nxt = FINISH;
            end
         end
         FINISH: begin
            state_nxt = accept ? HIT_DONE : IDLE;
         end
         default: begin
            state_nxt = IDLE;
         end
      endcase
   end

   // cache op, memory request and user outputs
   always_comb begin
      op          = '0;
      op.tag      = req_tag;
      op.index    = req_index;
      op.word_sel = req_word;
      op.wdata    = req_data;

      mem_req       = '0;
      mem_req.wdata = stat.rdata;

      done      = 1'b0;
      stall     = 1'b0;
      cache_hit = 1'b0;
      err       = 1'b0;

      case (state)
         HIT_DONE: begin
            op.enable = ~req_err;
            op.comp   = 1'b1;
            op.write  = req_wr;
            done      = req_err | line_hit;
            stall     = ~req_err & ~line_hit;
            cache_hit = ~req_err & line_hit;
            err       = req_err;
         end
         WB_ISSUE: begin
            // read the victim word, send it to its own bank
            op.enable         = 1'b1;
            op.word_sel       = issue_cnt;
            mem_req.valid     = 1'b1;
            mem_req.write     = 1'b1;
            mem_req.word_addr = {stat.tag_out, req_index, issue_cnt};
            stall             = 1'b1;
         end
         FILL_ISSUE, FILL_WAIT: begin
            // responses go straight into the line
            op.enable         = mem_resp.valid;
            op.write          = mem_resp.valid;
            op.valid_in       = 1'b1;
            op.word_sel       = recv_cnt;
            op.wdata          = mem_resp.rdata;
            mem_req.valid     = (state == FILL_ISSUE) && (in_flight < MAX_IN_FLIGHT);
            mem_req.word_addr = {req_tag, req_index, issue_cnt};
            stall             = 1'b1;
         end
         FINISH: begin
            op.enable = 1'b1;
            op.comp   = 1'b1;
            op.write  = req_wr;
            done      = 1'b1;
         end
         default: begin
            done = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== design/mem_bus_pkg.sv ====
/*
 structs that pass between controller, cache array and memory,
 and the controller state encoding
 mem_resp_t carries read data only; writes get no response
*/
`default_nettype none

package mem_bus_pkg;

   // controller to banked memory
   typedef struct packed {
      logic                valid;
      logic                write;
      addr_pkg::word_addr_t word_addr;
      addr_pkg::word_t     wdata;
   } mem_req_t;

   // banked memory to controller, read data in issue order
   typedef struct packed {
      logic            valid;
      addr_pkg::word_t rdata;
   } mem_resp_t;

   // controller to cache array
   typedef struct packed {
      logic                 enable;
      logic                 comp;     // compare mode, else access mode
      logic                 write;
      logic                 valid_in;
      addr_pkg::tag_t       tag;
      addr_pkg::index_t     index;
      addr_pkg::word_sel_t  word_sel;
      addr_pkg::word_t      wdata;
   } cache_op_t;

   // cache array to controller
   typedef struct packed {
      logic            hit;      // tag equal only, not qualified by valid
      logic            valid;
      logic            dirty;
      addr_pkg::tag_t  tag_out;
      addr_pkg::word_t rdata;
   } cache_stat_t;

   // controller states
   typedef enum logic [2:0] {
      IDLE,
      HIT_DONE,
      WB_ISSUE,
      FILL_ISSUE,
      FILL_WAIT,
      FINISH
   } ctrl_state_t;

endpackage

`default_nettype wire

// ==== design/mem_config.svh ====
/*
 shared geometry and timing for the cache and banked memory
 byte addresses, word data; bit 0 of an address must be zero
 index and tag widths must add up with the offset to ADDR_W
 MEM_WORDS covers the whole word address space
*/
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// address and data widths
`define ADDR_W            16
`define DATA_W            16

// cache geometry, direct mapped
`define TAG_W             5
`define INDEX_W           8
`define OFFSET_W          3
`define WORDS_PER_LINE    4

// main memory
`define NUM_BANKS         4
`define MEM_WORDS         32768

// cycles from an accepted read to its data
`define MEM_RD_LATENCY    2
// cycles a bank refuses requests after any accepted one
`define BANK_BUSY_CYCLES  4

`endif

// ==== design/mem_system.sv ====
/*
 top level: cache controller, direct-mapped cache array, banked memory
 one access at a time; wait for done before the next one
 data_out is meaningful only in a done cycle that answers a read
*/
`timescale 1ns/1ns
`default_nettype none

module mem_system (
   input  logic            clk,
   input  logic            rst,
   input  addr_pkg::addr_t addr,
   input  addr_pkg::word_t data_in,
   input  logic            rd,
   input  logic            wr,
   output addr_pkg::word_t data_out,
   output logic            done,
   output logic            stall,
   output logic            cache_hit,
   output logic            err
);
   import mem_bus_pkg::*;

   cache_op_t   cache_op;
   cache_stat_t cache_stat;
   mem_req_t    mem_req;
   mem_resp_t   mem_resp;
   logic        mem_ready;

   // read data straight from the array
   assign data_out = cache_stat.rdata;

   cache_ctrl ctrl_i (
      .clk       (clk),
      .rst       (rst),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .stat      (cache_stat),
      .op        (cache_op),
      .mem_req   (mem_req),
      .mem_ready (mem_ready),
      .mem_resp  (mem_resp),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   cache_array array_i (
      .clk  (clk),
      .rst  (rst),
      .op   (cache_op),
      .stat (cache_stat)
   );

   banked_mem mem_i (
      .clk   (clk),
      .rst   (rst),
      .req   (mem_req),
      .ready (mem_ready),
      .resp  (mem_resp)
   );

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+design
design/addr_pkg.sv
design/mem_bus_pkg.sv
design/cache_array.sv
design/banked_mem.sv
design/cache_ctrl.sv
design/mem_system.sv
tb/mem_system_tb.sv

// ==== tb/mem_system_tb.sv ====
/*
 directed testbench for the cache in front of the banked memory
 a shadow word memory and a per-index valid and tag model predict
 data_out and cache_hit; memory starts unknown, so only words that
 were written are ever read back
 one access at a time, each waiting on done within TIMEOUT_CYCLES
*/
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

module mem_system_tb;
   import addr_pkg::*;

   localparam int TIMEOUT_CYCLES = 200;
   localparam int NUM_LINES      = 1 << `INDEX_W;
   localparam int RANDOM_OPS     = 200;

   logic  clk;
   logic  rst;
   addr_t addr;
   word_t data_in;
   logic  rd;
   logic  wr;
   word_t data_out;
   logic  done;
   logic  stall;
   logic  cache_hit;
   logic  err;

   // shadow of main memory and of the line tags
   word_t shadow_mem [`MEM_WORDS];
   bit    written    [`MEM_WORDS];
   bit    line_valid [NUM_LINES];
   tag_t  line_tag   [NUM_LINES];

   logic [31:0] lcg_state;

   // what the last access returned
   word_t got_data;
   logic  got_hit;
   logic  got_err;
   logic  got_stall;
   int    got_cycles;

   mem_system mem_system_i (
      .clk       (clk),
      .rst       (rst),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   always begin
      #4 clk = ~clk;
   end

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic addr_t make_addr(input tag_t t, input index_t i, input word_sel_t w);
      return {t, i, w, 1'b0};
   endfunction

   task automatic check_equal(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         $display("FAILED at time %0t: %s is %0h, expected %0h", $time, name, got, expected);
         $display("ERRORS FOUND");
         $fatal(1, "value mismatch");
      end
   endtask

   // one request, then wait for the done pulse
   task automatic run_access(input logic do_rd, input logic do_wr, input addr_t a,
                             input word_t d);
      int   cycles;
      logic seen_done;
      logic seen_stall;
      logic stall_at_done;
      cycles        = 0;
      seen_done     = 1'b0;
      seen_stall    = 1'b0;
      stall_at_done = 1'b0;
      @(posedge clk);
      #1;
      addr    = a;
      data_in = d;
      rd      = do_rd;
      wr      = do_wr;
      @(posedge clk);
      #1;
      rd = 1'b0;
      wr = 1'b0;
      while (!seen_done && cycles < TIMEOUT_CYCLES) begin
         @(negedge clk);
         cycles++;
         if (done) begin
            seen_done     = 1'b1;
            got_data      = data_out;
            got_hit       = cache_hit;
            got_err       = err;
            stall_at_done = stall;
         end else begin
            if (stall) begin
               seen_stall = 1'b1;
            end
            // a miss stalls from the cycle after the request until done
            check_equal("stall", stall, 1);
            check_equal("cache_hit", cache_hit, 0);
            check_equal("err", err, 0);
         end
      end
      if (!seen_done) begin
         $display("no done within timeout at time %0t", $time);
         $display("ERRORS FOUND");
         $fatal(1, "timeout");
      end else begin
         got_cycles = cycles;
         got_stall  = seen_stall;
         check_equal("stall", stall_at_done, 0);
         // done lasts a single cycle
         @(negedge clk);
         check_equal("done", done, 0);
         check_equal("cache_hit", cache_hit, 0);
         check_equal("err", err, 0);
      end
   endtask

   // predict from the shadows, run, compare, then update the shadows
   task automatic access_and_check(input logic do_rd, input logic do_wr, input addr_t a,
                                   input word_t d);
      tag_t       t;
      index_t     i;
      word_addr_t wa;
      logic       exp_err;
      logic       exp_hit;
      t       = a[`ADDR_W-1 -: `TAG_W];
      i       = a[`OFFSET_W +: `INDEX_W];
      wa      = a[`ADDR_W-1:1];
      exp_err = (do_rd & do_wr) | a[0];
      exp_hit = !exp_err && line_valid[i] && (line_tag[i] == t);
      run_access(do_rd, do_wr, a, d);
      check_equal("err", got_err, exp_err);
      check_equal("cache_hit", got_hit, exp_hit);
      if (exp_err || exp_hit) begin
         check_equal("done latency", got_cycles, 1);
         check_equal("stall seen", got_stall, 0);
      end else begin
         check_equal("stall seen", got_stall, 1);
      end
      if (do_rd && !exp_err) begin
         check_equal("data_out", got_data, shadow_mem[wa]);
      end
      if (!exp_err) begin
         line_valid[i] = 1'b1;
         line_tag[i]   = t;
         if (do_wr) begin
            shadow_mem[wa] = d;
            written[wa]    = 1'b1;
         end
      end
   endtask

   task automatic write_word(input addr_t a, input word_t d);
      access_and_check(1'b0, 1'b1, a, d);
   endtask

   task automatic read_word(input addr_t a);
      access_and_check(1'b1, 1'b0, a, '0);
   endtask

   task automatic idle_after_reset();
      repeat (10) begin
         @(negedge clk);
         check_equal("done", done, 0);
         check_equal("stall", stall, 0);
         check_equal("err", err, 0);
         check_equal("cache_hit", cache_hit, 0);
      end
   endtask

   task automatic cold_write_then_read();
      write_word(make_addr(5'd1, 8'd10, 2'd1), 16'h1234);
      read_word(make_addr(5'd1, 8'd10, 2'd1));
   endtask

   // second write evicts a dirty line, then both come back
   task automatic evict_dirty_line();
      write_word(make_addr(5'd2, 8'd20, 2'd0), 16'ha5a5);
      write_word(make_addr(5'd9, 8'd20, 2'd0), 16'h5a5a);
      read_word(make_addr(5'd2, 8'd20, 2'd0));
      read_word(make_addr(5'd9, 8'd20, 2'd0));
   endtask

   task automatic hits_after_fill();
      for (int w = 0; w < `WORDS_PER_LINE; w++) begin
         write_word(make_addr(5'd3, 8'd40, word_sel_t'(w)), word_t'(16'h3100 + w));
      end
      write_word(make_addr(5'd12, 8'd40, 2'd0), 16'hc0de);
      read_word(make_addr(5'd3, 8'd40, 2'd2));
      read_word(make_addr(5'd3, 8'd40, 2'd0));
      read_word(make_addr(5'd3, 8'd40, 2'd1));
      read_word(make_addr(5'd3, 8'd40, 2'd3));
   endtask

   task automatic reject_bad_requests();
      write_word(make_addr(5'd4, 8'd60, 2'd2), 16'hbeef);
      access_and_check(1'b1, 1'b1, make_addr(5'd4, 8'd60, 2'd2), 16'h0bad);
      access_and_check(1'b1, 1'b0, make_addr(5'd4, 8'd60, 2'd2) | 16'h0001, '0);
      read_word(make_addr(5'd4, 8'd60, 2'd2));
   endtask

   // 3 tags, 4 indexes, 4 words; reads only hit written words
   task automatic random_accesses();
      logic [31:0] r;
      tag_t        t;
      index_t      i;
      addr_t       a;
      for (int n = 0; n < RANDOM_OPS; n++) begin
         r = next_random();
         t = tag_t'(6 + 7 * (r[23:16] % 3));
         i = index_t'(80 + 40 * r[25:24]);
         a = make_addr(t, i, r[27:26]);
         if (r[30] && written[a[`ADDR_W-1:1]]) begin
            read_word(a);
         end else begin
            r = next_random();
            write_word(a, r[31:16]);
         end
      end
   endtask

   initial begin
      clk       = 1'b0;
      rst       = 1'b1;
      addr      = '0;
      data_in   = '0;
      rd        = 1'b0;
      wr        = 1'b0;
      lcg_state = 32'd61815;
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      idle_after_reset();
      cold_write_then_read();
      evict_dirty_line();
      hits_after_fill();
      reject_bad_requests();
      random_accesses();
      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire
